/* fetch_frontend.f */
+incdir+src
src/fetch_pkg.sv
src/fetch_request_gen.sv
src/bus_tracker.sv
src/prefetch_queue.sv
src/instr_assembler.sv
src/fetch_frontend.sv
testbench/fetch_checker.sv
testbench/tb_fetch_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the fetch front-end testbench with Verilator and runs it into a log,
# a failing run or a fail message in the log gives a failing exit status
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fetch_frontend -f fetch_frontend.f -o tb_fetch_frontend \
	&& { ./obj_dir/tb_fetch_frontend > "$log" 2>&1 \
		|| echo "FAIL: see errors above" >> "$log"; } \
	|| { echo "verilator build failed"; exit 1; }
cat "$log"
grep -q "FAIL: see errors above" "$log" && exit 1 || exit 0

/* src/bus_tracker.sv */
// data phase bookkeeping: fetches in flight, stale fetches after a jump,
// halfword validity of returned words and the fetch stall for the request side
`timescale 1ns/10ps
`include "fetch_settings.svh"

module bus_tracker
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_word_t mem_rdata,
	input  logic        mem_data_vld,
	input  logic        req_accepted,
	input  logic        addr_hold,
	input  logic        jump_now,
	input  logic        jump_half,
	input  logic        room_for_fetch,
	input  logic        queue_empty,
	input  logic        queue_full,
	input  logic        queue_almost_full,
	output logic        fetch_stall,
	output fetch_word_t push_word,
	output logic        push,
	output logic        data_live
);

	logic [1:0] pending;
	logic [1:0] flush_cnt;
	// mask of the request sitting in the address phase
	hw_mask_t   aph_mask;
	// mask for the next word that comes back and is not flushed
	hw_mask_t   dph_mask;
	req_src_e   aph_src;

	// registered counts only, so bus ready never reaches the address phase
	// combinationally, at the cost of needing two queue entries
	assign fetch_stall = queue_full || (queue_almost_full && (pending != 2'd0)) ||
		(pending > 2'd1);

	// words requested before the last jump are dropped here
	assign data_live = mem_data_vld && (flush_cnt == 2'd0);

	// data that goes straight into the CIR is not written to the queue as well
	assign push = data_live && !(room_for_fetch && queue_empty);

	assign push_word.data = mem_rdata.data;
	assign push_word.err = mem_rdata.err;
	assign push_word.hw_vld = dph_mask;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 2'd0;
			flush_cnt <= 2'd0;
		end else begin
			pending <= pending + {1'b0, req_accepted} - {1'b0, mem_data_vld};
			// a request accepted in the jump cycle is the jump itself and stays
			if (jump_now) begin
				flush_cnt <= pending - {1'b0, mem_data_vld};
			end else if (mem_data_vld && (flush_cnt != 2'd0)) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// an odd jump target kills the lower halfword of its own word only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_mask <= 2'b11;
			dph_mask <= 2'b11;
		end else if (jump_now) begin
			if (req_accepted) begin
				aph_mask <= 2'b11;
				dph_mask <= {1'b1, !jump_half};
			end else begin
				aph_mask <= {1'b1, !jump_half};
				dph_mask <= 2'b11;
			end
		end else begin
			if (data_live) begin
				dph_mask <= 2'b11;
			end
			// a held jump leaves its mask behind once the bus takes it
			if (req_accepted && (aph_mask != 2'b11)) begin
				dph_mask <= aph_mask;
			end
			if (req_accepted) begin
				aph_mask <= 2'b11;
			end
		end
	end

	// what the request side did this cycle, as seen from here
	always_comb begin
		if (addr_hold) begin
			aph_src = REQ_HOLD;
		end else if (jump_now) begin
			aph_src = REQ_JUMP;
		end else if (req_accepted) begin
			aph_src = REQ_SEQ;
		end else begin
			aph_src = REQ_IDLE;
		end
	end

	a_pending_max: assert property (
		@(posedge clk) disable iff (!rst_n) pending <= 2'd2
	);
	a_no_orphan_data: assert property (
		@(posedge clk) disable iff (!rst_n) mem_data_vld |-> (pending != 2'd0)
	);
	// a fresh sequential fetch must never go out against a stall
	a_seq_obeys_stall: assert property (
		@(posedge clk) disable iff (!rst_n) (aph_src == REQ_SEQ) |-> !fetch_stall
	);

endmodule

/* src/fetch_frontend.sv */
// instruction fetch front end top: request generator, bus tracker,
// prefetch queue and instruction assembler between the bus and decode
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_frontend
	import fetch_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	// fetch bus
	output fetch_req_t               mem_req,
	output logic                     mem_addr_vld,
	input  logic                     mem_addr_rdy,
	input  fetch_word_t              mem_rdata,
	input  logic                     mem_data_vld,
	// jump port
	input  jump_req_t                jump,
	input  logic                     jump_vld,
	output logic                     jump_rdy,
	// decode port
	output logic [`FETCH_DATA_W-1:0] cir,
	output logic [1:0]               cir_vld,
	output logic [1:0]               cir_err,
	input  parcel_use_e              cir_use
);

	logic        jump_now;
	logic        req_accepted;
	logic        addr_hold;
	logic        fetch_stall;
	fetch_word_t push_word;
	logic        push;
	logic        data_live;
	logic        room_for_fetch;
	fetch_word_t queue_head;
	logic        queue_empty;
	logic        queue_full;
	logic        queue_almost_full;

	fetch_request_gen u_request_gen (
		.clk, .rst_n, .jump, .jump_vld, .jump_rdy, .mem_req, .mem_addr_vld,
		.mem_addr_rdy, .fetch_stall, .jump_now, .req_accepted, .addr_hold
	);

	// the halfword bit of the target decides which half of its word is live
	bus_tracker u_bus_tracker (
		.clk, .rst_n, .mem_rdata, .mem_data_vld, .req_accepted, .addr_hold, .jump_now,
		.jump_half(jump.target[1]), .room_for_fetch, .queue_empty, .queue_full,
		.queue_almost_full, .fetch_stall, .push_word, .push, .data_live
	);

	prefetch_queue u_prefetch_queue (
		.clk, .rst_n, .push_word, .push, .room_for_fetch, .jump_now, .head(queue_head),
		.empty(queue_empty), .full(queue_full), .almost_full(queue_almost_full)
	);

	// the word being pushed doubles as the bypass when the queue is empty
	instr_assembler u_instr_assembler (
		.clk, .rst_n, .head(queue_head), .queue_empty, .bypass_word(push_word),
		.data_live, .cir_use, .jump_now, .room_for_fetch, .cir, .cir_vld, .cir_err
	);

endmodule

/* src/fetch_pkg.sv */
// types shared by the fetch front-end modules and the testbench
// import with a wildcard in the module header

`include "fetch_settings.svh"

package fetch_pkg;

	// one flag per halfword of a fetch word, bit 0 is the lower halfword
	typedef logic [1:0] hw_mask_t;

	// address-phase payload of a fetch
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
		logic                     priv;
	} fetch_req_t;

	// one fetched word with its bus error and the halfwords that are live
	typedef struct packed {
		logic [`FETCH_DATA_W-1:0] data;
		logic                     err;
		hw_mask_t                 hw_vld;
	} fetch_word_t;

	// redirect from the core, target may be halfword aligned
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] target;
		logic                     priv;
	} jump_req_t;

	// where the address phase comes from, in priority order
	typedef enum logic [1:0] {REQ_HOLD, REQ_JUMP, REQ_SEQ, REQ_IDLE} req_src_e;

	// number of halfwords decode takes out of the CIR this cycle
	typedef enum logic [1:0] {USE_NONE = 2'd0, USE_ONE = 2'd1, USE_TWO = 2'd2} parcel_use_e;

endpackage

/* src/fetch_request_gen.sv */
// address phase of the fetch bus: word fetch counter, jump redirect and hold
// the request is steady from the first cycle of mem_addr_vld until accepted
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_request_gen
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  jump_req_t  jump,
	input  logic       jump_vld,
	output logic       jump_rdy,
	output fetch_req_t mem_req,
	output logic       mem_addr_vld,
	input  logic       mem_addr_rdy,
	input  logic       fetch_stall,
	output logic       jump_now,
	output logic       req_accepted,
	output logic       addr_hold
);

	localparam logic [`FETCH_ADDR_W-1:0] WORD_STEP = `FETCH_ADDR_W'(4);

	// fetch_addr runs ahead of the program counter in whole words
	logic [`FETCH_ADDR_W-1:0] fetch_addr;
	logic                     fetch_priv;
	logic [`FETCH_ADDR_W-1:0] jump_word;
	req_src_e                 req_src;

	// a jump can only be taken while no address phase is stuck on the bus
	assign jump_rdy = !addr_hold;
	assign jump_now = jump_vld && jump_rdy;
	assign jump_word = {jump.target[`FETCH_ADDR_W-1:2], 2'b00};

	// ------------------------------------------------------------------
	// request mux

	// a jump taken while two fetches are in flight only redirects the
	// counter, its own fetch follows once the stall lifts
	always_comb begin
		if (addr_hold) begin
			req_src = REQ_HOLD;
		end else if (jump_vld && !fetch_stall) begin
			req_src = REQ_JUMP;
		end else if (!fetch_stall) begin
			req_src = REQ_SEQ;
		end else begin
			req_src = REQ_IDLE;
		end
	end

	always_comb begin
		mem_req.addr = fetch_addr;
		mem_req.priv = fetch_priv;
		unique case (req_src)
			// the jump goes out the same cycle, already word aligned
			REQ_JUMP: begin
				mem_req.addr = jump_word;
				mem_req.priv = jump.priv;
			end
			// a held jump target was parked in fetch_addr, so hold and
			// sequential requests both show the counter
			default: begin
				mem_req.addr = fetch_addr;
				mem_req.priv = fetch_priv;
			end
		endcase
	end

	assign mem_addr_vld = (req_src != REQ_IDLE);
	assign req_accepted = mem_addr_vld && mem_addr_rdy;

	// ------------------------------------------------------------------
	// fetch counter and address hold

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= `FETCH_RESET_VECTOR;
			// machine mode out of reset
			fetch_priv <= 1'b1;
			addr_hold <= 1'b0;
		end else begin
			if (jump_now) begin
				// step past the target when the bus took it right away
				fetch_addr <= req_accepted ? jump_word + WORD_STEP : jump_word;
				fetch_priv <= jump.priv;
			end else if (req_accepted) begin
				fetch_addr <= fetch_addr + WORD_STEP;
			end
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
		end
	end

	// the bus may sample the request in any cycle of the hold
	a_req_stable_in_hold: assert property (
		@(posedge clk) disable iff (!rst_n) addr_hold |-> $stable(mem_req)
	);

endmodule

/* src/fetch_settings.svh */
// widths, queue depth and reset vector of the instruction fetch front end
// included by the package and by every front-end module

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// byte address width of the fetch bus
`define FETCH_ADDR_W 32

// one fetch returns a full word, always word aligned
`define FETCH_DATA_W 32

// an instruction parcel, two of them per fetch word
`define HALFWORD_W 16

// two entries are enough to cover two fetches in flight while decode stalls
`define PREFETCH_DEPTH 2

// the first fetch leaves from here, in machine mode
`define FETCH_RESET_VECTOR 32'h0000_0000

`endif

/* src/instr_assembler.sv */
// instruction assembly into the CIR from the queue head or the bus bypass
// decode takes 0, 1 or 2 halfwords a cycle, the rest shifts down and is topped up
`timescale 1ns/10ps
`include "fetch_settings.svh"

module instr_assembler
	import fetch_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  fetch_word_t              head,
	input  logic                     queue_empty,
	input  fetch_word_t              bypass_word,
	input  logic                     data_live,
	input  parcel_use_e              cir_use,
	input  logic                     jump_now,
	output logic                     room_for_fetch,
	output logic [`FETCH_DATA_W-1:0] cir,
	output logic [1:0]               cir_vld,
	output logic [1:0]               cir_err
);

	localparam int HW = `HALFWORD_W;

	// buf_level counts valid halfwords in {hwbuf, cir}, at most three
	logic [1:0]      buf_level;
	logic [HW-1:0]   hwbuf;
	logic [2:0]      err_buf;

	fetch_word_t     fetch;
	logic            fetch_vld;
	logic [2*HW-1:0] fetch_aligned;
	logic [3*HW-1:0] data_shifted;
	logic [3*HW-1:0] data_next;
	logic [2:0]      err_shifted;
	logic [2:0]      err_next;
	logic [2:0]      level_mask;
	logic [1:0]      use_cnt;
	logic [1:0]      level_rem;
	logic [1:0]      fill;
	logic [1:0]      level_next;

	// ------------------------------------------------------------------
	// fetch source

	// the bus word is only looked at when the queue has nothing older
	assign fetch = queue_empty ? bypass_word : head;
	assign fetch_vld = !queue_empty || data_live;
	// an odd start drops the upper halfword into the lower slot
	assign fetch_aligned = {fetch.data[2*HW-1:HW],
		fetch.hw_vld[0] ? fetch.data[HW-1:0] : fetch.data[2*HW-1:HW]};

	assign use_cnt = cir_use;
	assign level_rem = buf_level - use_cnt;
	// a half-valid word fits where a whole one would not
	assign room_for_fetch = level_rem <= ((&fetch.hw_vld) ? 2'd1 : 2'd2);
	assign fill = (room_for_fetch && fetch_vld) ? ((&fetch.hw_vld) ? 2'd2 : 2'd1) : 2'd0;
	assign level_next = jump_now ? 2'd0 : level_rem + fill;

	// ------------------------------------------------------------------
	// shift out consumed halfwords, then overlay fresh data

	always_comb begin
		unique case (cir_use)
			USE_TWO: begin
				data_shifted = {{2*HW{1'b0}}, hwbuf};
				err_shifted = {2'b00, err_buf[2]};
			end
			USE_ONE: begin
				data_shifted = {{HW{1'b0}}, hwbuf, cir[2*HW-1:HW]};
				err_shifted = {1'b0, err_buf[2:1]};
			end
			default: begin
				data_shifted = {hwbuf, cir};
				err_shifted = err_buf;
			end
		endcase
	end

	// errors ride along with the halfwords of the word they came with
	always_comb begin
		data_next = data_shifted;
		err_next = err_shifted;
		if (room_for_fetch) begin
			unique case (level_rem)
				2'd2: begin
					data_next = {fetch_aligned[HW-1:0], data_shifted[2*HW-1:0]};
					err_next = {fetch.err, err_shifted[1:0]};
				end
				2'd1: begin
					data_next = {fetch_aligned, data_shifted[HW-1:0]};
					err_next = {{2{fetch.err}}, err_shifted[0]};
				end
				default: begin
					data_next = {data_shifted[3*HW-1:2*HW], fetch_aligned};
					err_next = {err_shifted[2], {2{fetch.err}}};
				end
			endcase
		end
	end

	// error flags never outlive the halfwords they belong to
	always_comb begin
		unique case (level_next)
			2'd0: level_mask = 3'b000;
			2'd1: level_mask = 3'b001;
			2'd2: level_mask = 3'b011;
			default: level_mask = 3'b111;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
			err_buf <= 3'b000;
		end else begin
			buf_level <= level_next;
			cir_vld <= (level_next > 2'd2) ? 2'd2 : level_next;
			err_buf <= err_next & level_mask;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = err_buf[1:0];

	// decode must never take more than it was shown
	a_use_le_vld: assert property (
		@(posedge clk) disable iff (!rst_n) use_cnt <= cir_vld
	);
	// taking halfwords out never wraps the level below zero
	a_level_no_wrap: assert property (
		@(posedge clk) disable iff (!rst_n) level_rem <= buf_level
	);

endmodule

/* src/prefetch_queue.sv */
// compacting prefetch queue between the bus and the instruction assembler
// entry 0 is the head, a push lands in the lowest free slot after any pop
`timescale 1ns/10ps
`include "fetch_settings.svh"

module prefetch_queue
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_word_t push_word,
	input  logic        push,
	input  logic        room_for_fetch,
	input  logic        jump_now,
	output fetch_word_t head,
	output logic        empty,
	output logic        full,
	output logic        almost_full
);

	localparam int DEPTH = `PREFETCH_DEPTH;

	logic [`FETCH_DATA_W-1:0] q_data [DEPTH];
	logic                     q_err  [DEPTH];
	hw_mask_t                 q_hw   [DEPTH];

	// one slot past the top stands for the incoming word, never valid itself
	fetch_word_t slot      [DEPTH+1];
	logic        slot_vld  [DEPTH+1];
	logic        below_vld [DEPTH];
	logic        pop;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			slot[i].data = q_data[i];
			slot[i].err = q_err[i];
			slot[i].hw_vld = q_hw[i];
		end
		slot[DEPTH].data = push_word.data;
		slot[DEPTH].err = push_word.err;
		slot[DEPTH].hw_vld = 2'b00;
		for (int i = 0; i <= DEPTH; i++) begin
			slot_vld[i] = |slot[i].hw_vld;
		end
		// the head slot always has a valid neighbour below
		for (int i = 0; i < DEPTH; i++) begin
			below_vld[i] = (i == 0) ? 1'b1 : slot_vld[i-1];
		end
	end

	assign empty = !slot_vld[0];
	assign full = slot_vld[DEPTH-1];
	assign almost_full = slot_vld[DEPTH-2];
	assign head = slot[0];
	assign pop = room_for_fetch && !empty;

	// payload moves down on a pop, or fills an empty slot on a push
	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (pop || (push && !slot_vld[i])) begin
				q_data[i] <= slot_vld[i+1] ? slot[i+1].data : push_word.data;
				q_err[i] <= slot_vld[i+1] ? slot[i+1].err : push_word.err;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				q_hw[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (jump_now) begin
					q_hw[i] <= 2'b00;
				end else if (slot_vld[i+1] && pop) begin
					q_hw[i] <= slot[i+1].hw_vld;
				end else if (slot_vld[i] && pop) begin
					// top valid entry leaves, the new word takes its place
					q_hw[i] <= push ? push_word.hw_vld : 2'b00;
				end else if (slot_vld[i]) begin
					q_hw[i] <= q_hw[i];
				end else if (push && !pop && below_vld[i]) begin
					q_hw[i] <= push_word.hw_vld;
				end else begin
					q_hw[i] <= 2'b00;
				end
			end
		end
	end

	// the head is always the oldest word
	a_compact: assert property (
		@(posedge clk) disable iff (!rst_n) !slot_vld[0] |-> !slot_vld[1]
	);
	// the tracker stalls fetches early enough that a push always fits
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n) (push && full) |-> pop
	);

endmodule

/* testbench/fetch_checker.sv */
// watches the fetch front-end ports, models the program counter from the
// memory rule and counts value and protocol errors for the testbench top
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_checker
	import fetch_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  fetch_req_t               mem_req,
	input  logic                     mem_addr_vld,
	input  logic                     mem_addr_rdy,
	input  logic                     mem_data_vld,
	input  jump_req_t                jump,
	input  logic                     jump_vld,
	input  logic                     jump_rdy,
	input  logic [`FETCH_DATA_W-1:0] cir,
	input  logic [1:0]               cir_vld,
	input  logic [1:0]               cir_err,
	input  parcel_use_e              cir_use,
	output int                       value_errors,
	output int                       protocol_errors,
	output int                       instr_count
);

	// pc is the address of the instruction at the bottom of the CIR
	logic [`FETCH_ADDR_W-1:0] pc;
	logic                     exp_priv;
	logic                     first_req_seen;
	logic                     first_cycle_seen;
	logic                     hold_prev;
	fetch_req_t               req_prev;
	int                       outstanding;

	// a halfword carries its own address bits, the low bits give its length
	function automatic logic [15:0] expected_parcel(input logic [`FETCH_ADDR_W-1:0] a);
		return {a[14:1], a[3] ? 2'b11 : 2'b01};
	endfunction

	initial begin
		value_errors = 0;
		protocol_errors = 0;
		instr_count = 0;
	end

	// ------------------------------------------------------------------
	// bus side checks

	always @(posedge clk) begin
		logic cur_priv;
		if (!rst_n) begin
			exp_priv = 1'b1;
			first_req_seen = 1'b0;
			hold_prev = 1'b0;
			outstanding = 0;
		end else begin
			if (mem_addr_vld && !first_req_seen) begin
				first_req_seen = 1'b1;
				if (mem_req.addr != `FETCH_RESET_VECTOR) begin
					$display("[FAIL] mem_req.addr = %h, expected %h", mem_req.addr,
						`FETCH_RESET_VECTOR);
					value_errors++;
				end
			end
			// a request that was not taken must be shown again unchanged
			if (hold_prev && !mem_addr_vld) begin
				$display("mem_addr_vld dropped before the held request was accepted");
				protocol_errors++;
			end else if (hold_prev && (mem_req != req_prev)) begin
				$display("[FAIL] mem_req = %h, expected %h while held", mem_req, req_prev);
				protocol_errors++;
			end
			// the jump request itself already carries the new privilege
			cur_priv = (jump_vld && jump_rdy) ? jump.priv : exp_priv;
			if (mem_addr_vld && (mem_req.priv != cur_priv)) begin
				$display("[FAIL] mem_req.priv = %h, expected %h", mem_req.priv, cur_priv);
				value_errors++;
			end
			if (jump_vld && jump_rdy && mem_addr_vld &&
				(mem_req.addr != {jump.target[`FETCH_ADDR_W-1:2], 2'b00})) begin
				$display("[FAIL] mem_req.addr = %h, expected %h", mem_req.addr,
					{jump.target[`FETCH_ADDR_W-1:2], 2'b00});
				value_errors++;
			end
			exp_priv = cur_priv;
			outstanding = outstanding + int'(mem_addr_vld && mem_addr_rdy) - int'(mem_data_vld);
			if (outstanding > 2 || outstanding < 0) begin
				$display("fetch count on the bus left the range 0 to 2 (%0d)", outstanding);
				protocol_errors++;
			end
			hold_prev = mem_addr_vld && !mem_addr_rdy;
			req_prev = mem_req;
		end
	end

	// ------------------------------------------------------------------
	// decode side checks

	always @(posedge clk) begin
		logic [`FETCH_DATA_W-1:0] exp_cir;
		logic [`FETCH_DATA_W-1:0] got_cir;
		logic [1:0]               exp_err;
		logic [1:0]               live;
		if (!rst_n) begin
			pc = `FETCH_RESET_VECTOR;
			first_cycle_seen = 1'b0;
		end else begin
			if (!first_cycle_seen && (cir_vld != 2'd0)) begin
				$display("[FAIL] cir_vld = %h, expected 0 after reset", cir_vld);
				value_errors++;
			end
			first_cycle_seen = 1'b1;
			// error flags only ever sit on halfwords that are shown
			live = (cir_vld == 2'd0) ? 2'b00 : ((cir_vld == 2'd1) ? 2'b01 : 2'b11);
			if ((cir_err & ~live) != 2'b00) begin
				$display("[FAIL] cir_err = %h, expected %h", cir_err, cir_err & live);
				value_errors++;
			end
			if (cir_use != USE_NONE) begin
				if (cir_use == USE_TWO) begin
					exp_cir = {expected_parcel(pc + 32'd2), expected_parcel(pc)};
					got_cir = cir;
					exp_err = {(pc + 32'd2) >> 8 & 32'd1 ? 1'b1 : 1'b0, pc[8]};
				end else begin
					exp_cir = {16'h0000, expected_parcel(pc)};
					got_cir = {16'h0000, cir[15:0]};
					exp_err = {1'b0, pc[8]};
				end
				if (got_cir != exp_cir) begin
					$display("[FAIL] cir = %h, expected %h at pc %h", got_cir, exp_cir, pc);
					value_errors++;
				end
				if ((cir_err & ((cir_use == USE_TWO) ? 2'b11 : 2'b01)) != exp_err) begin
					$display("[FAIL] cir_err = %h, expected %h at pc %h", cir_err, exp_err, pc);
					value_errors++;
				end
				pc = pc + ((cir_use == USE_TWO) ? 32'd4 : 32'd2);
				instr_count++;
			end
			// everything after a jump starts at the target
			if (jump_vld && jump_rdy) begin
				pc = jump.target;
			end
		end
	end

endmodule

/* testbench/tb_fetch_frontend.sv */
// testbench top for the fetch front end with clock, reset, a fetch bus memory
// model, a stimulus table of decode stalls and jumps, and the decode consumer
`timescale 1ns/10ps
`include "fetch_settings.svh"

module tb_fetch_frontend
	import fetch_pkg::*;
();

	localparam int NUM_STEPS = 8;
	localparam int WAIT_LIMIT = 200;
	localparam logic [1:0] STALL_NONE = 2'd0;
	localparam logic [1:0] STALL_RANDOM = 2'd1;
	localparam logic [1:0] STALL_ALT = 2'd2;

	// one row of the stimulus table, the jump is taken before the cycles run
	typedef struct packed {
		logic [15:0] cycles;
		logic [1:0]  stall_mode;
		logic        bus_random;
		logic        do_jump;
		logic [31:0] target;
		logic        priv;
	} step_t;

	logic                     clk;
	logic                     rst_n;
	fetch_req_t               mem_req;
	logic                     mem_addr_vld;
	logic                     mem_addr_rdy;
	fetch_word_t              mem_rdata;
	logic                     mem_data_vld;
	jump_req_t                jump;
	logic                     jump_vld;
	logic                     jump_rdy;
	logic [`FETCH_DATA_W-1:0] cir;
	logic [1:0]               cir_vld;
	logic [1:0]               cir_err;
	parcel_use_e              cir_use;
	int                       value_errors;
	int                       protocol_errors;
	int                       instr_count;
	int                       timeout_errors;
	step_t                    steps [NUM_STEPS];
	logic                     bus_random;
	logic                     alt_phase;
	int                       next_lat;
	int                       bus_cycle;
	// accepted fetches waiting for their data, oldest first
	logic [31:0]              req_addr_q [$];
	int                       req_due_q [$];

	fetch_frontend dut (
		.clk, .rst_n, .mem_req, .mem_addr_vld, .mem_addr_rdy, .mem_rdata, .mem_data_vld,
		.jump, .jump_vld, .jump_rdy, .cir, .cir_vld, .cir_err, .cir_use
	);

	fetch_checker u_checker (
		.clk, .rst_n, .mem_req, .mem_addr_vld, .mem_addr_rdy, .mem_data_vld, .jump,
		.jump_vld, .jump_rdy, .cir, .cir_vld, .cir_err, .cir_use, .value_errors,
		.protocol_errors, .instr_count
	);

	always #4 clk = ~clk;

	function automatic logic [15:0] halfword_at(input logic [31:0] a);
		return {a[14:1], a[3] ? 2'b11 : 2'b01};
	endfunction

	// words in the 0x100 to 0x1ff range of every 512 bytes fault
	function automatic fetch_word_t memory_word(input logic [31:0] addr);
		fetch_word_t w;
		w.data = {halfword_at(addr + 32'd2), halfword_at(addr)};
		w.err = addr[8];
		w.hw_vld = 2'b11;
		return w;
	endfunction

	// ------------------------------------------------------------------
	// memory model, address phase side

	always @(posedge clk) begin
		if (!rst_n) begin
			req_addr_q.delete();
			req_due_q.delete();
			bus_cycle = 0;
		end else begin
			if (mem_data_vld) begin
				req_addr_q.delete(0);
				req_due_q.delete(0);
			end
			if (mem_addr_vld && mem_addr_rdy) begin
				req_addr_q.push_back(mem_req.addr);
				req_due_q.push_back(bus_cycle + next_lat);
			end
			bus_cycle++;
		end
	end

	// one falling edge of stimulus, returned data first and then decode
	task automatic drive_cycle(input logic [1:0] stall_mode, input logic hold_decode);
		logic       stall;
		logic [1:0] need;
		@(negedge clk);
		if ((req_addr_q.size() != 0) && (req_due_q[0] <= bus_cycle)) begin
			mem_data_vld = 1'b1;
			mem_rdata = memory_word(req_addr_q[0]);
		end else begin
			mem_data_vld = 1'b0;
		end
		mem_addr_rdy = bus_random ? ($urandom_range(3) != 0) : 1'b1;
		next_lat = 1 + $urandom_range(2);
		alt_phase = !alt_phase;
		case (stall_mode)
			STALL_RANDOM: stall = ($urandom_range(2) == 0);
			STALL_ALT: stall = alt_phase;
			default: stall = 1'b0;
		endcase
		// decode only takes a whole instruction
		need = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
		if (hold_decode || stall || (cir_vld < need)) begin
			cir_use = USE_NONE;
		end else begin
			cir_use = parcel_use_e'(need);
		end
	endtask

	// jump_rdy is registered, so after a falling edge it holds until the
	// rising edge that takes the jump
	task automatic take_jump(input logic [31:0] target, input logic priv,
		input logic [1:0] stall_mode);
		int waited;
		waited = 0;
		jump.target = target;
		jump.priv = priv;
		jump_vld = 1'b1;
		cir_use = USE_NONE;
		while (!jump_rdy && (waited < WAIT_LIMIT)) begin
			drive_cycle(stall_mode, 1'b1);
			waited++;
		end
		if (!jump_rdy) begin
			$display("jump to %h was never accepted", target);
			timeout_errors++;
		end
		drive_cycle(stall_mode, 1'b1);
		jump_vld = 1'b0;
	endtask

	task automatic wait_progress(input int from_count, input logic [1:0] stall_mode);
		int waited;
		waited = 0;
		while ((instr_count <= from_count) && (waited < WAIT_LIMIT)) begin
			drive_cycle(stall_mode, 1'b0);
			waited++;
		end
		if (instr_count <= from_count) begin
			$display("decode saw no new instruction within %0d cycles", WAIT_LIMIT);
			timeout_errors++;
		end
	endtask

	initial begin
		int seed_val;
		int start_count;
		seed_val = $urandom(49865);
		clk = 1'b0;
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_rdata = '0;
		mem_data_vld = 1'b0;
		jump = '0;
		jump_vld = 1'b0;
		cir_use = USE_NONE;
		timeout_errors = 0;
		bus_random = 1'b0;
		alt_phase = 1'b0;
		next_lat = 1;
		// odd targets, error regions and their edges, random bus and decode stalls
		steps[0] = '{16'd60, STALL_NONE, 1'b0, 1'b0, 32'h0000_0000, 1'b1};
		steps[1] = '{16'd80, STALL_RANDOM, 1'b1, 1'b0, 32'h0000_0000, 1'b1};
		steps[2] = '{16'd60, STALL_NONE, 1'b0, 1'b1, 32'h0000_010a, 1'b0};
		steps[3] = '{16'd60, STALL_ALT, 1'b1, 1'b1, 32'h0000_00f6, 1'b1};
		steps[4] = '{16'd80, STALL_RANDOM, 1'b1, 1'b1, 32'h0000_0200, 1'b0};
		steps[5] = '{16'd80, STALL_RANDOM, 1'b1, 1'b1, 32'h0000_01fe, 1'b1};
		steps[6] = '{16'd40, STALL_NONE, 1'b1, 1'b1, 32'h0000_040e, 1'b0};
		steps[7] = '{16'd100, STALL_RANDOM, 1'b1, 1'b0, 32'h0000_0000, 1'b0};
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int s = 0; s < NUM_STEPS; s++) begin
			bus_random = steps[s].bus_random;
			if (steps[s].do_jump) begin
				take_jump(steps[s].target, steps[s].priv, steps[s].stall_mode);
			end
			start_count = instr_count;
			for (int c = 0; c < int'(steps[s].cycles); c++) begin
				drive_cycle(steps[s].stall_mode, 1'b0);
			end
			wait_progress(start_count, steps[s].stall_mode);
		end
		$display("errors: value %0d, protocol %0d, timeout %0d, instructions %0d",
			value_errors, protocol_errors, timeout_errors, instr_count);
		if ((value_errors + protocol_errors + timeout_errors) == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
